// File: Makefile
# Verilator build and run for the multiply unit

VERILATOR ?= verilator
TOP       ?= mul_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  := all tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: files.f
logic/mul_pkg.sv
logic/booth_pp_gen.sv
logic/booth_mul.sv
logic/mul_unit.sv
test/mul_checker.sv
test/mul_tb.sv

// File: logic/booth_mul.sv
`timescale 1ns/1ns

module booth_mul import mul_pkg::*; (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 start,
	input  logic [MUL_EXT_W-1:0] mcand,
	input  logic [MUL_EXT_W-1:0] mplier,
	input  logic [5:0]           steps,
	input  logic                 flush,
	output logic                 busy,
	output logic                 done,
	output mul_resp_t            product
);

	//**********************************************************
	// state and datapath registers
	//**********************************************************

	mul_state_e state_q;
	// steps issued so far
	logic [5:0] cnt_q;
	// step count latched at start
	logic [5:0] steps_q;

	logic [MUL_EXT_W-1:0] mcand_q;
	// multiplier shift register, low two bits feed the recoder
	logic [MUL_EXT_W-1:0] mq_q;
	// bit shifted out below mq_q[0], zero at start
	logic                 mlow_q;

	// running sum
	logic [MUL_PP_W-1:0] acc_q;
	// registered partial product, added one cycle later
	logic [MUL_PP_W-1:0] pp_q;
	logic [MUL_PP_W-1:0] pp_w;

	// current booth digit
	logic [2:0] digit;

	assign digit = {mq_q[1:0], mlow_q};

	booth_pp_gen pp_gen (
		.digit (digit),
		.mcand (mcand_q),
		.step  (cnt_q),
		.pp    (pp_w)
	);

	//**********************************************************
	// sequencer
	//**********************************************************

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= ST_IDLE;
			cnt_q   <= '0;
		end else begin
			unique case (state_q)
				ST_IDLE: begin
					if (start) begin
						state_q <= ST_RUN;
						cnt_q   <= '0;
					end
				end
				ST_RUN: begin
					// flush drops the request, no done
					if (flush) begin
						state_q <= ST_IDLE;
					end else if (cnt_q == steps_q) begin
						// last add lands on this edge
						state_q <= ST_DONE;
					end else begin
						cnt_q <= cnt_q + 6'd1;
					end
				end
				ST_DONE: begin
					// back-to-back request in the done cycle
					if (start) begin
						state_q <= ST_RUN;
						cnt_q   <= '0;
					end else begin
						state_q <= ST_IDLE;
					end
				end
				default: begin
					state_q <= ST_IDLE;
				end
			endcase
		end
	end

	//**********************************************************
	// accumulate datapath
	//**********************************************************

	always_ff @(posedge clk) begin
		if (start) begin
			mcand_q <= mcand;
			mq_q    <= mplier;
			mlow_q  <= 1'b0;
			acc_q   <= '0;
			// nothing to add on the first run edge
			pp_q    <= '0;
			steps_q <= steps;
		end else if (state_q == ST_RUN) begin
			acc_q  <= acc_q + pp_q;
			pp_q   <= pp_w;
			// shift in sign, top digits are never past the end
			mq_q   <= {{2{mq_q[MUL_EXT_W-1]}}, mq_q[MUL_EXT_W-1:2]};
			mlow_q <= mq_q[1];
		end
	end

	//**********************************************************
	// outputs
	//**********************************************************

	assign busy = (state_q == ST_RUN);
	assign done = (state_q == ST_DONE);

	// low 128 bits are the product, valid while done
	assign product.hi = acc_q[2*MUL_XLEN-1:MUL_XLEN];
	assign product.lo = acc_q[MUL_XLEN-1:0];

	//**********************************************************
	// checks
	//**********************************************************

	// done is a single-cycle pulse
	a_done_pulse: assert property (@(posedge clk) disable iff (rst)
		done |=> !done);

	// top level must hold off requests while running
	a_no_start_busy: assert property (@(posedge clk) disable iff (rst)
		busy |-> !start);

	// a flushed run never completes
	a_flush_kills: assert property (@(posedge clk) disable iff (rst)
		(flush && state_q == ST_RUN) |=> (!done && !busy));

endmodule

// File: logic/booth_pp_gen.sv
`timescale 1ns/1ns

module booth_pp_gen import mul_pkg::*; (
	input  logic [2:0]           digit,
	input  logic [MUL_EXT_W-1:0] mcand,
	input  logic [5:0]           step,
	output logic [MUL_PP_W-1:0]  pp
);

	// multiplicand, sign-extended to accumulator width
	logic [MUL_PP_W-1:0] m1;
	// two times the multiplicand
	logic [MUL_PP_W-1:0] m2;
	// selected magnitude before negation
	logic [MUL_PP_W-1:0] mag;
	// partial product before positioning
	logic [MUL_PP_W-1:0] signed_pp;
	logic                neg;

	//**********************************************************
	// radix-4 recoding
	//**********************************************************

	always_comb begin
		m1 = {{(MUL_PP_W - MUL_EXT_W){mcand[MUL_EXT_W-1]}}, mcand};
		m2 = m1 << 1;

		// digit is {b[2i+1], b[2i], b[2i-1]}
		case (digit)
			3'b001, 3'b010: begin
				mag = m1;
				neg = 1'b0;
			end
			3'b011: begin
				mag = m2;
				neg = 1'b0;
			end
			3'b100: begin
				mag = m2;
				neg = 1'b1;
			end
			3'b101, 3'b110: begin
				mag = m1;
				neg = 1'b1;
			end
			// 000 and 111 contribute nothing
			default: begin
				mag = '0;
				neg = 1'b0;
			end
		endcase

		// two's complement negate
		signed_pp = neg ? (~mag + 1'b1) : mag;

		// each digit weighs 4^step
		pp = signed_pp << {step, 1'b0};
	end

endmodule

// File: logic/mul_pkg.sv
package mul_pkg;

	//**********************************************************
	// widths and step counts
	//**********************************************************

	// operand width fixed by the ISA
	localparam int MUL_XLEN = 64;
	// two extra multiplier bits give a whole number of booth digits
	localparam int MUL_EXT_W = 66;
	// radix-4 steps, 66 bits / 2
	localparam int MUL_STEPS_D = 33;
	// word mode only needs 34 bits of multiplier
	localparam int MUL_STEPS_W = 17;
	// partial product and accumulator width
	localparam int MUL_PP_W = 130;

	//**********************************************************
	// enums
	//**********************************************************

	// bit 1 marks a signed multiplicand, bit 0 a signed multiplier
	typedef enum logic [1:0] {
		MUL_UU = 2'b00,
		MUL_SU = 2'b10,
		MUL_SS = 2'b11
	} mul_sign_e;

	// sequencer states
	typedef enum logic [1:0] {
		ST_IDLE = 2'b00,
		ST_RUN  = 2'b01,
		ST_DONE = 2'b10
	} mul_state_e;

	//**********************************************************
	// request and response
	//**********************************************************

	typedef struct packed {
		logic                word;
		mul_sign_e           sign;
		logic [MUL_XLEN-1:0] mcand;
		logic [MUL_XLEN-1:0] mplier;
	} mul_req_t;

	// full 128-bit product, or the formatted word result
	typedef struct packed {
		logic [MUL_XLEN-1:0] hi;
		logic [MUL_XLEN-1:0] lo;
	} mul_resp_t;

endpackage

// File: logic/mul_unit.sv
`timescale 1ns/1ns

module mul_unit import mul_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      req_valid,
	input  mul_req_t  req,
	input  logic      flush,
	output logic      ready,
	output logic      resp_valid,
	output mul_resp_t resp
);

	// accepted request strobe
	logic start;
	logic busy;
	logic done;

	// operands extended by sign mode
	logic [MUL_EXT_W-1:0] mcand_ext;
	logic [MUL_EXT_W-1:0] mplier_ext;
	logic [5:0]           steps;

	mul_resp_t raw;
	// word flag of the request in flight
	logic      word_q;

	//**********************************************************
	// operand staging
	//**********************************************************

	// word mode keeps only the low 32 bits
	function automatic logic [MUL_EXT_W-1:0] ext_op(
		input logic [MUL_XLEN-1:0] val,
		input logic                sgn,
		input logic                word
	);
		logic [MUL_EXT_W-1:0] res;
		if (word) begin
			res = {{(MUL_EXT_W - 32){sgn & val[31]}}, val[31:0]};
		end else begin
			res = {{(MUL_EXT_W - MUL_XLEN){sgn & val[MUL_XLEN-1]}}, val};
		end
		return res;
	endfunction

	assign start = req_valid & ready;

	// SU and SS both treat the multiplicand as signed
	assign mcand_ext  = ext_op(req.mcand, req.sign != MUL_UU, req.word);
	assign mplier_ext = ext_op(req.mplier, req.sign == MUL_SS, req.word);

	assign steps = req.word ? 6'(MUL_STEPS_W) : 6'(MUL_STEPS_D);

	always_ff @(posedge clk) begin
		if (rst) begin
			word_q <= 1'b0;
		end else if (start) begin
			word_q <= req.word;
		end
	end

	booth_mul seq (
		.clk     (clk),
		.rst     (rst),
		.start   (start),
		.mcand   (mcand_ext),
		.mplier  (mplier_ext),
		.steps   (steps),
		.flush   (flush),
		.busy    (busy),
		.done    (done),
		.product (raw)
	);

	//**********************************************************
	// result formatting
	//**********************************************************

	assign ready      = ~busy;
	assign resp_valid = done;

	always_comb begin
		if (word_q) begin
			// 32-bit result sign-extended, upper word likewise
			resp.lo = {{32{raw.lo[31]}}, raw.lo[31:0]};
			resp.hi = {{32{raw.lo[63]}}, raw.lo[63:32]};
		end else begin
			resp = raw;
		end
	end

endmodule

// File: test/mul_cases.txt
# columns: word sign mcand mplier flush
# word 0/1, sign 0=uu 1=su 2=ss, operands hex, flush = edge after acceptance (0 none)
0 0 0000000000000000 0000000000000000 0
0 0 0000000000000001 0000000000000001 0
0 0 ffffffffffffffff ffffffffffffffff 0
0 1 ffffffffffffffff ffffffffffffffff 0
0 2 ffffffffffffffff ffffffffffffffff 0
0 2 8000000000000000 8000000000000000 0
0 1 8000000000000000 ffffffffffffffff 0
0 0 8000000000000000 0000000000000002 0
0 2 8000000000000000 0000000000000001 0
0 2 7fffffffffffffff 8000000000000000 0
0 1 0000000000000001 8000000000000000 0
0 0 0123456789abcdef fedcba9876543210 0
0 1 0123456789abcdef fedcba9876543210 0
0 2 0123456789abcdef fedcba9876543210 0
0 2 0000000000000001 ffffffffffffffff 0
0 2 0000000000000002 0000000000000002 0
0 2 0000000000000003 fffffffffffffffd 0
0 2 0000000000000004 0000000000000004 0
0 2 0000000000000005 fffffffffffffffb 0
1 0 00000000ffffffff 00000000ffffffff 0
1 1 00000000ffffffff 00000000ffffffff 0
1 2 00000000ffffffff 00000000ffffffff 0
1 1 deadbeef80000000 1234567800000002 0
1 2 deadbeef80000000 cafef00d80000000 0
1 2 ffffffff7fffffff 0000000180000000 0
1 0 1111111100000000 2222222212345678 0
1 2 aaaaaaaa00000001 5555555500000001 0
1 0 0000000000000000 ffffffffffffffff 0
0 2 0123456789abcdef 0fedcba987654321 1
0 0 ffffffffffffffff 0000000000000003 0
0 1 8000000000000001 7fffffffffffffff 10
0 2 0000000000000007 fffffffffffffff9 34
1 2 0000000012345678 0000000087654321 18
1 0 00000000ffffffff 0000000000000010 5
0 0 0000000000000009 0000000000000009 0

// File: test/mul_checker.sv
`timescale 1ns/1ns

module mul_checker import mul_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      req_valid,
	input  mul_req_t  req,
	input  logic      flush,
	input  logic      ready,
	input  logic      resp_valid,
	input  mul_resp_t resp,
	input  logic      report,
	output int        finished,
	output int        errors
);

	// at most one request in flight
	mul_req_t inflight[$];
	// rising edges since acceptance
	int       edges;
	int       accepted;
	int       passed;
	int       flushed;

	//**********************************************************
	// reference product from wide arithmetic
	//**********************************************************

	function automatic mul_resp_t expected(input mul_req_t r);
		logic         a_sgn;
		logic         b_sgn;
		logic [127:0] a;
		logic [127:0] b;
		logic [127:0] p;
		mul_resp_t    e;
		a_sgn = r.sign inside {MUL_SU, MUL_SS};
		b_sgn = (r.sign == MUL_SS);
		if (r.word) begin
			// upper operand halves play no part
			a = {{96{a_sgn & r.mcand[31]}}, r.mcand[31:0]};
			b = {{96{b_sgn & r.mplier[31]}}, r.mplier[31:0]};
		end else begin
			a = {{64{a_sgn & r.mcand[63]}}, r.mcand};
			b = {{64{b_sgn & r.mplier[63]}}, r.mplier};
		end
		p = a * b;
		if (r.word) begin
			e.lo = {{32{p[31]}}, p[31:0]};
			e.hi = {{32{p[63]}}, p[63:32]};
		end else begin
			e.hi = p[127:64];
			e.lo = p[63:0];
		end
		return e;
	endfunction

	task automatic compare_response();
		mul_req_t  r;
		mul_resp_t e;
		int        want;
		logic      bad;
		r = inflight.pop_front();
		e = expected(r);
		// cycles from acceptance to the response cycle
		want = r.word ? 18 : 34;
		bad = 1'b0;
		if (resp.hi !== e.hi) begin
			$display("MISMATCH at %0t: test %0d hi %h, expected %h",
				$time, finished + 1, resp.hi, e.hi);
			bad = 1'b1;
		end
		if (resp.lo !== e.lo) begin
			$display("MISMATCH at %0t: test %0d lo %h, expected %h",
				$time, finished + 1, resp.lo, e.lo);
			bad = 1'b1;
		end
		// resp_valid is sampled one edge after the latency window
		if (edges - 1 != want) begin
			$display("at %0t: test %0d answered after %0d cycles instead of %0d",
				$time, finished + 1, edges - 1, want);
			bad = 1'b1;
		end
		// the next request may be taken in the response cycle
		if (!ready) begin
			$display("at %0t: ready is low in the response cycle of test %0d",
				$time, finished + 1);
			bad = 1'b1;
		end
		finished++;
		if (bad) begin
			errors++;
		end else begin
			passed++;
		end
		$display("test %0d %s: %s word=%0d %h x %h", finished, bad ? "wrong" : "ok",
			r.sign.name(), r.word, r.mcand, r.mplier);
	endtask

	//**********************************************************
	// port watcher
	//**********************************************************

	always @(posedge clk) begin
		if (rst) begin
			inflight.delete();
			edges = 0;
			accepted = 0;
			passed = 0;
			flushed = 0;
			finished = 0;
			errors = 0;
		end else begin
			if (inflight.size() != 0) begin
				edges++;
				if (resp_valid) begin
					compare_response();
				end else if (ready) begin
					$display("at %0t: ready is high while test %0d is running",
						$time, finished + 1);
					errors++;
				end else if (flush) begin
					inflight.delete(0);
					finished++;
					flushed++;
					$display("test %0d flushed on edge %0d, no response due", finished, edges);
				end
			end else begin
				if (resp_valid) begin
					$display("at %0t: a response came with no request in flight", $time);
					errors++;
				end
				if (!ready) begin
					$display("at %0t: ready is low with no request in flight", $time);
					errors++;
				end
			end
			// back-to-back acceptance lands after the compare above
			if (req_valid && ready) begin
				inflight.push_back(req);
				accepted++;
				edges = 0;
			end
		end
	end

	always @(posedge report) begin
		$display("totals: %0d accepted, %0d ok, %0d flushed, %0d errors",
			accepted, passed, flushed, errors);
	end

endmodule

// File: test/mul_tb.sv
`timescale 1ns/1ns

module mul_tb import mul_pkg::*; ();

	logic        clk;
	logic        rst;
	logic        req_valid;
	mul_req_t    req;
	logic        flush;
	logic        ready;
	logic        resp_valid;
	mul_resp_t   resp;
	// checker reports its totals on the rising edge
	logic        report;
	int          finished;
	int          errors;
	int          load_errors;
	int          num_cases;
	logic [31:0] rng;

	// file cases first, random ones after
	mul_req_t case_req[$];
	// edge after acceptance that carries flush, 0 for none
	int       case_flush[$];

	mul_unit UUT (.*);

	mul_checker chk (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	//**********************************************************
	// case sources
	//**********************************************************

	// xorshift32 step on the shared seed
	function automatic logic [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	task automatic read_cases();
		int          fd;
		int          n;
		int          w;
		int          s;
		int          f;
		logic [63:0] a;
		logic [63:0] b;
		string       line;
		mul_req_t    r;
		fd = $fopen("test/mul_cases.txt", "r");
		if (fd == 0) begin
			$display("cannot open the case file test/mul_cases.txt");
			load_errors++;
			return;
		end
		while ($fgets(line, fd) > 0) begin
			// comment lines
			if (line.substr(0, 0) == "#") begin
				continue;
			end
			n = $sscanf(line, "%d %d %h %h %d", w, s, a, b, f);
			if (n == 5 && s >= 0 && s <= 2) begin
				r.word = w[0];
				r.sign = (s == 2) ? MUL_SS : (s == 1) ? MUL_SU : MUL_UU;
				r.mcand = a;
				r.mplier = b;
				case_req.push_back(r);
				case_flush.push_back(f);
			end else if (n > 0) begin
				$display("malformed line in the case file: %s", line);
				load_errors++;
			end
		end
		$fclose(fd);
	endtask

	task automatic add_random_cases(input int count);
		mul_req_t    r;
		logic [31:0] sel;
		int          f;
		for (int i = 0; i < count; i++) begin
			r.mcand[63:32] = next_rand();
			r.mcand[31:0] = next_rand();
			r.mplier[63:32] = next_rand();
			r.mplier[31:0] = next_rand();
			sel = next_rand();
			r.word = sel[0];
			r.sign = (sel[2:1] == 2'd2) ? MUL_SS : (sel[2:1] == 2'd1) ? MUL_SU : MUL_UU;
			// an extreme operand now and then
			if (sel[6:4] == 3'd0) begin
				r.mcand = 64'h8000_0000_0000_0000;
			end
			if (sel[9:7] == 3'd0) begin
				r.mplier = '1;
			end
			// a few get flushed, anywhere in the run window
			f = 0;
			if (sel[20:16] < 5'd3) begin
				f = 1 + int'(sel[31:21]) % (r.word ? 18 : 34);
			end
			case_req.push_back(r);
			case_flush.push_back(f);
		end
	endtask

	//**********************************************************
	// stimulus, all on the falling edge
	//**********************************************************

	task automatic send_case(input mul_req_t r, input int flush_at, input logic poke);
		while (!ready) begin
			@(negedge clk);
		end
		req_valid = 1'b1;
		req = r;
		// acceptance edge lies behind this negedge
		@(negedge clk);
		req_valid = 1'b0;
		if (flush_at > 0) begin
			repeat (flush_at - 1) @(negedge clk);
			flush = 1'b1;
			@(negedge clk);
			flush = 1'b0;
		end else if (poke) begin
			// unit is busy, this strobe must be dropped
			@(negedge clk);
			req_valid = 1'b1;
			req.mcand = ~r.mcand;
			@(negedge clk);
			req_valid = 1'b0;
		end
	endtask

	initial begin
		rst = 1'b1;
		req_valid = 1'b0;
		req = '0;
		flush = 1'b0;
		report = 1'b0;
		load_errors = 0;
		rng = 32'h17fa_7f05;
		read_cases();
		add_random_cases(200);
		num_cases = case_req.size();
		repeat (8) @(negedge clk);
		rst = 1'b0;
		for (int i = 0; i < num_cases; i++) begin
			send_case(case_req[i], case_flush[i], i[0]);
		end
		while (finished < num_cases) begin
			@(negedge clk);
		end
		// quiet window for a stray response
		repeat (40) @(negedge clk);
		report = 1'b1;
		@(negedge clk);
		if (errors == 0 && load_errors == 0 && finished == num_cases) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	// watchdog, budget of 40 periods per case
	initial begin
		wait (num_cases > 0);
		repeat (num_cases * 40 + 100) @(posedge clk);
		$display("timeout: the run did not finish in %0d clock periods", num_cases * 40 + 100);
		$display("tests failed");
		$finish;
	end

endmodule
